// ==== source/rv32i_pkg.sv ====
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;                // data and address word
    typedef logic [4:0]  rv32i_reg;                 // register index

    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,                      // register-register alu
        op_imm   = 7'b0010011,                      // register-immediate alu
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } rv32i_opcode;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10                          // lui result
    } alu_op_t;

    localparam rv32i_word RESET_PC = 32'h0000_0000;
    localparam int        NUM_REGS = 32;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;        // add / sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;        // srl / sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef struct packed {
        rv32i_word pc;
        rv32i_word instr;
    } fd_payload_t;

    typedef struct packed {
        rv32i_word pc;
        rv32i_word rs1_data;
        rv32i_word rs2_data;
        rv32i_reg  rs1;
        rv32i_reg  rs2;
        rv32i_reg  rd;
        rv32i_word imm;
        alu_op_t   alu_op;
        logic      use_imm;                         // operand b from imm
        logic      use_pc;                          // operand a from pc
        logic      reg_write;
    } de_payload_t;

    typedef struct packed {
        rv32i_word pc;
        rv32i_reg  rd;
        rv32i_word result;
        logic      reg_write;
    } ew_payload_t;

endpackage : rv32i_pkg

// ==== source/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;                     // bubbles travel with the data
        end
    end

    always_ff @(posedge clk) begin
        data_o <= data_i;                           // payload taken every edge
    end

endmodule : stage_reg

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
    import rv32i_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        imem_resp_i,
    input  rv32i_word   imem_rdata_i,
    output logic        imem_read_o,
    output rv32i_word   imem_addr_o,
    output logic        fetch_valid_o,
    output fd_payload_t fetch_o
);

    rv32i_word pc_q;
    logic      gap_q;                               // read held low this cycle

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q  <= RESET_PC;
            gap_q <= 1'b1;                          // keeps the read low in reset
        end else begin
            gap_q <= imem_resp_i;                   // one idle cycle per response
            if (imem_resp_i) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    assign imem_read_o = ~gap_q;
    assign imem_addr_o = pc_q;

    // instruction goes straight to fd_reg on the response cycle
    assign fetch_valid_o = imem_resp_i;
    assign fetch_o.pc    = pc_q;
    assign fetch_o.instr = imem_rdata_i;

endmodule : fetch_stage

// ==== source/regfile.sv ====
`timescale 1ns/1ps

module regfile
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      we_i,
    input  rv32i_reg  waddr_i,
    input  rv32i_word wdata_i,
    input  rv32i_reg  raddr1_i,
    input  rv32i_reg  raddr2_i,
    output rv32i_word rdata1_o,
    output rv32i_word rdata2_o
);

    rv32i_word regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;               // x0 never written
        end
    end

    // same-cycle write is seen by the reader
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && (waddr_i == raddr1_i)) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && (waddr_i == raddr2_i)) ? wdata_i : regs[raddr2_i];

endmodule : regfile

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import rv32i_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        valid_i,
    input  fd_payload_t fetch_i,
    input  logic        wb_we_i,
    input  rv32i_reg    wb_rd_i,
    input  rv32i_word   wb_data_i,
    output logic        valid_o,
    output de_payload_t decode_o
);

    rv32i_word   instr;
    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic        alt;                               // instr[30] selects sub and sra
    rv32i_word   i_imm;
    rv32i_word   u_imm;
    rv32i_word   rs1_data;
    rv32i_word   rs2_data;
    alu_op_t     funct_op;

    assign instr  = fetch_i.instr;
    assign opcode = rv32i_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];
    assign i_imm  = {{20{instr[31]}}, instr[31:20]};
    assign u_imm  = {instr[31:12], 12'h000};

    regfile rf (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_rd_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (instr[19:15]),
        .raddr2_i (instr[24:20]),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    always_comb begin
        case (funct3)
            F3_ADD:  funct_op = (alt && (opcode == op_reg)) ? alu_sub : alu_add;
            F3_SLL:  funct_op = alu_sll;
            F3_SLT:  funct_op = alu_slt;
            F3_SLTU: funct_op = alu_sltu;
            F3_XOR:  funct_op = alu_xor;
            F3_SR:   funct_op = alt ? alu_sra : alu_srl;   // srai shares the bit
            F3_OR:   funct_op = alu_or;
            F3_AND:  funct_op = alu_and;
            default: funct_op = alu_add;
        endcase
    end

    always_comb begin
        decode_o.pc        = fetch_i.pc;
        decode_o.rs1_data  = rs1_data;
        decode_o.rs2_data  = rs2_data;
        decode_o.rs1       = instr[19:15];
        decode_o.rs2       = instr[24:20];
        decode_o.rd        = instr[11:7];
        decode_o.imm       = i_imm;
        decode_o.alu_op    = funct_op;
        decode_o.use_imm   = 1'b0;
        decode_o.use_pc    = 1'b0;
        decode_o.reg_write = 1'b0;                  // other opcodes retire silently
        case (opcode)
            op_reg: begin
                decode_o.reg_write = 1'b1;
            end
            op_imm: begin
                decode_o.use_imm   = 1'b1;
                decode_o.reg_write = 1'b1;
            end
            op_lui: begin
                decode_o.imm       = u_imm;
                decode_o.alu_op    = alu_pass_b;
                decode_o.use_imm   = 1'b1;
                decode_o.reg_write = 1'b1;
            end
            op_auipc: begin
                decode_o.imm       = u_imm;
                decode_o.alu_op    = alu_add;
                decode_o.use_imm   = 1'b1;
                decode_o.use_pc    = 1'b1;
                decode_o.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    assign valid_o = valid_i;

endmodule : decode_stage

// ==== source/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage
    import rv32i_pkg::*;
(
    input  logic        valid_i,
    input  de_payload_t decode_i,
    input  logic        fwd_we_i,
    input  rv32i_reg    fwd_rd_i,
    input  rv32i_word   fwd_data_i,
    output logic        valid_o,
    output ew_payload_t exec_o
);

    logic      fwd_rs1;
    logic      fwd_rs2;
    rv32i_word rs1_val;
    rv32i_word rs2_val;
    rv32i_word op_a;
    rv32i_word op_b;
    logic [4:0] shamt;
    rv32i_word result;

    // writeback register result beats the value read in decode
    assign fwd_rs1 = fwd_we_i && (fwd_rd_i != '0) && (fwd_rd_i == decode_i.rs1);
    assign fwd_rs2 = fwd_we_i && (fwd_rd_i != '0) && (fwd_rd_i == decode_i.rs2);
    assign rs1_val = fwd_rs1 ? fwd_data_i : decode_i.rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_data_i : decode_i.rs2_data;

    assign op_a  = decode_i.use_pc  ? decode_i.pc  : rs1_val;
    assign op_b  = decode_i.use_imm ? decode_i.imm : rs2_val;
    assign shamt = op_b[4:0];                       // low 5 bits only

    always_comb begin
        case (decode_i.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << shamt;
            alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   result = {31'b0, op_a < op_b};
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> shamt;
            alu_sra:    result = rv32i_word'($signed(op_a) >>> shamt);
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

    assign exec_o.pc        = decode_i.pc;
    assign exec_o.rd        = decode_i.rd;
    assign exec_o.result    = result;
    assign exec_o.reg_write = decode_i.reg_write;
    assign valid_o          = valid_i;

endmodule : exe_stage

// ==== source/rv32i_core.sv ====
`timescale 1ns/1ps

module rv32i_core
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    output logic      imem_read_o,
    output rv32i_word imem_addr_o,
    input  logic      imem_resp_i,
    input  rv32i_word imem_rdata_i,
    output logic      commit_valid_o,
    output rv32i_word commit_pc_o,
    output rv32i_reg  commit_rd_o,
    output rv32i_word commit_wdata_o
);

    logic        fetch_valid;
    logic        fd_valid;
    logic        dec_valid;
    logic        de_valid;
    logic        exe_valid;
    logic        ew_valid;
    fd_payload_t fetch_data;
    fd_payload_t fd_data;
    de_payload_t dec_data;
    de_payload_t de_data;
    ew_payload_t exe_data;
    ew_payload_t ew_data;
    logic        wb_we;

    fetch_stage fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .imem_resp_i   (imem_resp_i),
        .imem_rdata_i  (imem_rdata_i),
        .imem_read_o   (imem_read_o),
        .imem_addr_o   (imem_addr_o),
        .fetch_valid_o (fetch_valid),
        .fetch_o       (fetch_data)
    );

    stage_reg #(.payload_t(fd_payload_t)) fd_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (fetch_valid),
        .data_i  (fetch_data),
        .valid_o (fd_valid),
        .data_o  (fd_data)
    );

    decode_stage decode (
        .clk       (clk),
        .reset_i   (reset_i),
        .valid_i   (fd_valid),
        .fetch_i   (fd_data),
        .wb_we_i   (wb_we),
        .wb_rd_i   (ew_data.rd),
        .wb_data_i (ew_data.result),
        .valid_o   (dec_valid),
        .decode_o  (dec_data)
    );

    stage_reg #(.payload_t(de_payload_t)) de_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (dec_valid),
        .data_i  (dec_data),
        .valid_o (de_valid),
        .data_o  (de_data)
    );

    exe_stage execute (
        .valid_i    (de_valid),
        .decode_i   (de_data),
        .fwd_we_i   (wb_we),
        .fwd_rd_i   (ew_data.rd),
        .fwd_data_i (ew_data.result),
        .valid_o    (exe_valid),
        .exec_o     (exe_data)
    );

    stage_reg #(.payload_t(ew_payload_t)) ew_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (exe_valid),
        .data_i  (exe_data),
        .valid_o (ew_valid),
        .data_o  (ew_data)
    );

    // x0 writes still reach the commit port
    assign wb_we          = ew_valid & ew_data.reg_write;
    assign commit_valid_o = wb_we;
    assign commit_pc_o    = ew_data.pc;
    assign commit_rd_o    = ew_data.rd;
    assign commit_wdata_o = ew_data.result;

endmodule : rv32i_core

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps

module core_tb
    import rv32i_pkg::*;
();

    localparam int NUM_INSTR = 400;
    localparam int SEED      = 43884;
    localparam int TIMEOUT   = 16 + NUM_INSTR * 6 + 50;

    logic      clk;
    logic      reset_i;
    logic      imem_read_o;
    rv32i_word imem_addr_o;
    logic      imem_resp_i;
    rv32i_word imem_rdata_i;
    logic      commit_valid_o;
    rv32i_word commit_pc_o;
    rv32i_reg  commit_rd_o;
    rv32i_word commit_wdata_o;

    rv32i_word program_mem [NUM_INSTR];
    rv32i_word exp_pc [$];
    rv32i_reg  exp_rd [$];
    rv32i_word exp_val [$];
    int        errors    = 0;
    int        commits   = 0;
    int        cycles    = 0;
    int        wait_cnt  = 0;
    int        fetch_idx = 0;                       // responses given so far
    logic      armed     = 1'b0;                    // latency picked for current read
    int        n_expected;

    rv32i_core uut (
        .clk            (clk),
        .reset_i        (reset_i),
        .imem_read_o    (imem_read_o),
        .imem_addr_o    (imem_addr_o),
        .imem_resp_i    (imem_resp_i),
        .imem_rdata_i   (imem_rdata_i),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_rd_o    (commit_rd_o),
        .commit_wdata_o (commit_wdata_o)
    );

    task automatic check_eq(input string name, input rv32i_word got, input rv32i_word expected);
        if (got !== expected) begin
            $display("ERR %0t: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    // small register range so dependencies at distance 1 and 2 are frequent
    function automatic rv32i_word random_instr();
        rv32i_reg   rd;
        rv32i_reg   rs1;
        rv32i_reg   rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        int         kind;
        rd   = 5'($urandom % 8);
        rs1  = 5'($urandom % 8);
        rs2  = 5'($urandom % 8);
        f3   = 3'($urandom);
        f7   = (((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom % 2 == 1)) ? 7'b0100000 : 7'b0;
        imm  = 12'($urandom);
        kind = $urandom % 20;
        if (kind == 0) begin
            return {25'($urandom), 7'b0000011};     // load opcode is unsupported
        end else if (kind < 8) begin
            return {f7, rs2, rs1, f3, rd, op_reg};
        end else if (kind < 15) begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {(f3 == 3'd5) ? f7 : 7'b0, rs2};  // shift amount in rs2 slot
            end
            return {imm, rs1, f3, rd, op_imm};
        end else if (kind < 18) begin
            return {20'($urandom), rd, op_lui};
        end
        return {20'($urandom), rd, op_auipc};
    endfunction

    function automatic rv32i_word alu_ref(input logic [2:0] f3, input logic alt,
                                          input rv32i_word a, input rv32i_word b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? rv32i_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // in-order run of the whole program with one expected commit per supported instr
    task automatic build_model();
        rv32i_word regs_m [32];
        rv32i_word ins;
        rv32i_word pc;
        rv32i_word b;
        rv32i_word res;
        logic      ok;
        for (int r = 0; r < 32; r++) regs_m[r] = '0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            ins = program_mem[i];
            pc  = RESET_PC + 32'(i * 4);
            b   = (ins[6:0] == op_reg) ? regs_m[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
            ok  = 1'b1;
            case (ins[6:0])
                op_reg, op_imm: res = alu_ref(ins[14:12],
                    ins[30] && ((ins[6:0] == op_reg) || (ins[14:12] == 3'd5)),
                    regs_m[ins[19:15]], b);
                op_lui:   res = {ins[31:12], 12'h000};
                op_auipc: res = {ins[31:12], 12'h000} + pc;
                default:  ok = 1'b0;                // bubble retires without a commit
            endcase
            if (ok) begin
                exp_pc.push_back(pc);
                exp_rd.push_back(ins[11:7]);
                exp_val.push_back(res);
                if (ins[11:7] != 5'd0) regs_m[ins[11:7]] = res;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory answers 0 to 3 cycles after the read goes up
    always @(posedge clk) begin
        #2;
        if (imem_resp_i) begin
            imem_resp_i = 1'b0;                     // fetch drops the read next
            armed       = 1'b0;
            check_eq("imem read gap", 32'(imem_read_o), 32'd0);
        end else if (imem_read_o) begin
            if (!armed) begin
                wait_cnt = $urandom % 4;
                armed    = 1'b1;
            end
            check_eq("imem addr", imem_addr_o, RESET_PC + 32'(fetch_idx * 4));
            if (wait_cnt == 0) begin
                imem_resp_i  = 1'b1;
                imem_rdata_i = ((imem_addr_o >> 2) < NUM_INSTR) ?
                               program_mem[imem_addr_o[10:2]] : 32'h0000_0000;
                fetch_idx++;
            end else begin
                wait_cnt--;
            end
        end
    end

    always @(negedge clk) begin
        if (!reset_i && commit_valid_o) begin
            if (exp_pc.size() == 0) begin
                $display("Unexpected commit at pc %h after the last instruction", commit_pc_o);
                errors++;
            end else begin
                check_eq("commit pc", commit_pc_o, exp_pc.pop_front());
                check_eq("commit rd", 32'(commit_rd_o), 32'(exp_rd.pop_front()));
                check_eq("commit wdata", commit_wdata_o, exp_val.pop_front());
            end
            commits++;
        end
    end

    initial begin
        reset_i      = 1'b1;
        imem_resp_i  = 1'b0;
        imem_rdata_i = '0;
        void'($urandom(SEED));
        for (int i = 0; i < NUM_INSTR; i++) program_mem[i] = random_instr();
        build_model();
        n_expected = exp_pc.size();
        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
            #2;
            check_eq("imem read in reset", 32'(imem_read_o), 32'd0);
            check_eq("commit valid in reset", 32'(commit_valid_o), 32'd0);
        end
        reset_i = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_eq("first imem read", 32'(imem_read_o), 32'd1);
        check_eq("first imem addr", imem_addr_o, RESET_PC);
        while (commits < n_expected && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (commits < n_expected) begin
            $display("The run hung: %0d of %0d commits seen in %0d cycles",
                     commits, n_expected, cycles);
            errors++;
        end else begin
            repeat (10) @(posedge clk);             // catch stray commits
            if (commits != n_expected) begin
                $display("Wrong number of commits: %0d seen, %0d expected",
                         commits, n_expected);
                errors++;
            end
        end
        $display("errors %0d, commits %0d of %0d", errors, commits, n_expected);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : core_tb

// ==== vlog.f ====
source/rv32i_pkg.sv
source/stage_reg.sv
source/fetch_stage.sv
source/regfile.sv
source/decode_stage.sv
source/exe_stage.sv
source/rv32i_core.sv
verification/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary -f vlog.f --top-module core_tb -o core_tb_sim
./obj_dir/core_tb_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "core_tb: passed"
else
    echo "core_tb: failed, see sim.log"
    exit 1
fi
